/* ddr_axi_pkg.sv */
package ddr_axi_pkg;

   //////////////////////////////
   // axi channel widths
   //////////////////////////////

   // one data beat on the 64-bit bus
   typedef logic [63:0] axi_data_t;

   // byte address into ddr
   typedef logic [31:0] axi_addr_t;

   // burst length, beats minus one as axi encodes it
   typedef logic [7:0]  axi_len_t;

   // bytes per beat as a power of two
   typedef logic [1:0]  axi_size_t;

   //////////////////////////////
   // fixed burst attributes
   //////////////////////////////

   // incrementing burst code on awburst/arburst
   localparam logic [1:0] axi_burst_incr = 2'b01;

   // every byte lane of the 64-bit beat is written
   localparam logic [7:0] axi_strb_all = 8'hff;

endpackage

/* ddr_page_pkg.sv */
package ddr_page_pkg;

   //////////////////////////////
   // page bookkeeping widths
   //////////////////////////////

   // pages written, read or programmed
   typedef logic [31:0] page_cnt_t;

   // base page offset added to every page index
   typedef logic [19:0] page_ofs_t;

   // bursts issued within one read command
   typedef logic [7:0]  burst_cnt_t;

   //////////////////////////////
   // engine fsm states
   //////////////////////////////

   // write address channel
   typedef enum logic [1:0] {wr_idle, wr_addr, wr_wait_resp} wr_state_e;

   // write data channel
   typedef enum logic [1:0] {wd_idle, wd_beats, wd_done} wd_state_e;

   // read address and data channels
   typedef enum logic [1:0] {rd_idle, rd_addr, rd_data, rd_done} rd_state_e;

endpackage

/* ddr_page_tracker.sv */
`timescale 1ns/100ps

module ddr_page_tracker
(
   input  logic                    sysclk_i,
   input  logic                    reset,
   input  logic                    write_cmd_i,
   input  logic                    read_cmd_i,
   input  logic                    write_done_i,
   input  logic                    read_done_i,
   input  ddr_page_pkg::page_cnt_t write_pages_i,
   output logic                    write_go_o,
   output ddr_page_pkg::page_cnt_t wr_page_o,
   output ddr_page_pkg::page_cnt_t rd_page_o,
   output logic                    last_write_o,
   output logic                    mem_full_o
);

   // pages written to ddr since the last restart
   ddr_page_pkg::page_cnt_t wr_cnt;
   // read commands seen since the last restart
   ddr_page_pkg::page_cnt_t rd_cnt;
   // page count frozen when memory filled up
   ddr_page_pkg::page_cnt_t full_cnt;
   // single-cycle restart, clears counters and full flag
   logic restart_q;

   // a write is only accepted while there is room left
   assign write_go_o = write_cmd_i & ~mem_full_o;

   // engines sample the index before it increments
   assign wr_page_o = wr_cnt;
   assign rd_page_o = rd_cnt;

   //////////////////////////////
   // page counters
   //////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         wr_cnt <= '0;
         rd_cnt <= '0;
      end
      else if (restart_q)
      begin
         wr_cnt <= '0;
         rd_cnt <= '0;
      end
      else
      begin
         // write count moves at command time, not at completion
         if (write_go_o)
            wr_cnt <= wr_cnt + 1'b1;
         // read count also moves at the start of a read
         if (read_cmd_i)
            rd_cnt <= rd_cnt + 1'b1;
      end
   end

   //////////////////////////////
   // full flag and restart
   //////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         last_write_o <= 1'b0;
         mem_full_o   <= 1'b0;
         full_cnt     <= '0;
         restart_q    <= 1'b0;
      end
      else
      begin
         // true once the programmed number of pages has been issued
         last_write_o <= (wr_cnt == write_pages_i);

         // final page has landed, freeze the count for the read side
         if (restart_q)
            mem_full_o <= 1'b0;
         else if (write_done_i && last_write_o)
         begin
            mem_full_o <= 1'b1;
            full_cnt   <= wr_cnt;
         end

         // last page read back while full
         restart_q <= read_done_i & mem_full_o & (rd_cnt == full_cnt);
      end
   end

endmodule

/* ddr_write_engine.sv */
`timescale 1ns/100ps

module ddr_write_engine
#(
   parameter ddr_axi_pkg::axi_len_t  burst_len  = 8'd255,
   parameter ddr_axi_pkg::axi_size_t burst_size = 2'd3
)
(
   input  logic                    sysclk_i,
   input  logic                    reset,
   input  logic                    write_go_i,
   input  ddr_page_pkg::page_cnt_t wr_page_i,
   input  ddr_page_pkg::page_ofs_t mem_ofs_i,
   input  logic                    fifo_empty_i,
   input  ddr_axi_pkg::axi_data_t  fifo_data_i,
   input  logic                    awready_i,
   input  logic                    wready_i,
   input  logic                    bvalid_i,
   output logic                    fifo_re_o,
   output ddr_axi_pkg::axi_addr_t  awaddr_o,
   output logic                    awvalid_o,
   output ddr_axi_pkg::axi_data_t  wdata_o,
   output logic                    wvalid_o,
   output logic                    wlast_o,
   output logic                    bready_o,
   output logic                    write_done_o
);

   // bytes covered by one burst, beats times bytes per beat
   localparam ddr_axi_pkg::axi_addr_t burst_ofs =
      (ddr_axi_pkg::axi_addr_t'(burst_len) + 32'd1) << burst_size;

   ddr_page_pkg::wr_state_e wr_state;
   ddr_page_pkg::wd_state_e wd_state;
   // beat index within the current burst
   ddr_axi_pkg::axi_len_t   beat_cnt;
   // first byte of the page being written
   ddr_axi_pkg::axi_addr_t  start_addr;
   logic                    aw_hs;
   logic                    w_hs;

   assign start_addr = burst_ofs * (ddr_axi_pkg::axi_addr_t'(wr_page_i)
                     + ddr_axi_pkg::axi_addr_t'(mem_ofs_i));

   assign aw_hs = awvalid_o & awready_i;
   assign w_hs  = wvalid_o & wready_i;

   //////////////////////////////
   // write data path
   //////////////////////////////

   // show-ahead fifo, head word goes straight onto the bus
   assign wdata_o   = fifo_data_i;
   // valid drops while the fifo is starved, count is kept
   assign wvalid_o  = (wd_state == ddr_page_pkg::wd_beats) & ~fifo_empty_i;
   assign wlast_o   = (wd_state == ddr_page_pkg::wd_beats) & (beat_cnt == burst_len);
   // every accepted beat pops one word
   assign fifo_re_o = w_hs;
   // response is always taken
   assign bready_o  = 1'b1;

   // start address is captured with the command
   always_ff @(posedge sysclk_i)
   begin
      if (write_go_i && wr_state == ddr_page_pkg::wr_idle)
         awaddr_o <= start_addr;
   end

   //////////////////////////////
   // write address fsm
   //////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         wr_state     <= ddr_page_pkg::wr_idle;
         awvalid_o    <= 1'b0;
         write_done_o <= 1'b0;
      end
      else
      begin
         write_done_o <= 1'b0;
         case (wr_state)
            ddr_page_pkg::wr_idle:
            begin
               if (write_go_i)
               begin
                  awvalid_o <= 1'b1;
                  wr_state  <= ddr_page_pkg::wr_addr;
               end
            end
            // hold awvalid until the slave takes it
            ddr_page_pkg::wr_addr:
            begin
               if (awready_i)
               begin
                  awvalid_o <= 1'b0;
                  wr_state  <= ddr_page_pkg::wr_wait_resp;
               end
            end
            // response only counts once all beats are out
            ddr_page_pkg::wr_wait_resp:
            begin
               if (bvalid_i && wd_state == ddr_page_pkg::wd_done)
               begin
                  write_done_o <= 1'b1;
                  wr_state     <= ddr_page_pkg::wr_idle;
               end
            end
            default:
               wr_state <= ddr_page_pkg::wr_idle;
         endcase
      end
   end

   //////////////////////////////
   // write data fsm
   //////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         wd_state <= ddr_page_pkg::wd_idle;
         beat_cnt <= '0;
      end
      else
      begin
         case (wd_state)
            // beats start the cycle after the address handshake
            ddr_page_pkg::wd_idle:
            begin
               beat_cnt <= '0;
               if (aw_hs)
                  wd_state <= ddr_page_pkg::wd_beats;
            end
            ddr_page_pkg::wd_beats:
            begin
               if (w_hs)
               begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (beat_cnt == burst_len)
                     wd_state <= ddr_page_pkg::wd_done;
               end
            end
            // burst complete, wait for the slave to respond
            ddr_page_pkg::wd_done:
            begin
               if (bvalid_i)
                  wd_state <= ddr_page_pkg::wd_idle;
            end
            default:
               wd_state <= ddr_page_pkg::wd_idle;
         endcase
      end
   end

endmodule

/* ddr_read_engine.sv */
`timescale 1ns/100ps

module ddr_read_engine
#(
   parameter ddr_axi_pkg::axi_len_t  burst_len  = 8'd255,
   parameter ddr_axi_pkg::axi_size_t burst_size = 2'd3
)
(
   input  logic                     sysclk_i,
   input  logic                     reset,
   input  logic                     read_cmd_i,
   input  ddr_page_pkg::page_cnt_t  rd_page_i,
   input  ddr_page_pkg::page_ofs_t  mem_ofs_i,
   input  ddr_page_pkg::burst_cnt_t read_bursts_i,
   input  logic                     arready_i,
   input  ddr_axi_pkg::axi_data_t   rdata_i,
   input  logic                     rvalid_i,
   input  logic                     rlast_i,
   output ddr_axi_pkg::axi_addr_t   araddr_o,
   output logic                     arvalid_o,
   output logic                     rready_o,
   output ddr_axi_pkg::axi_data_t   memfifo_data_o,
   output logic                     memfifo_we_o,
   output logic                     read_done_o
);

   // address step between consecutive bursts
   localparam ddr_axi_pkg::axi_addr_t burst_ofs =
      (ddr_axi_pkg::axi_addr_t'(burst_len) + 32'd1) << burst_size;

   ddr_page_pkg::rd_state_e  rd_state;
   // bursts completed in this command
   ddr_page_pkg::burst_cnt_t burst_cnt;
   // bursts requested, held for the whole command
   ddr_page_pkg::burst_cnt_t n_bursts;
   ddr_axi_pkg::axi_addr_t   start_addr;
   logic                     r_hs;
   logic                     last_beat;
   logic                     final_burst;

   assign start_addr = burst_ofs * (ddr_axi_pkg::axi_addr_t'(rd_page_i)
                     + ddr_axi_pkg::axi_addr_t'(mem_ofs_i));

   // data is only expected after an address went out
   assign rready_o    = (rd_state == ddr_page_pkg::rd_data);
   assign r_hs        = rvalid_i & rready_o;
   assign last_beat   = r_hs & rlast_i;
   assign final_burst = (ddr_page_pkg::burst_cnt_t'(burst_cnt + 1'b1) == n_bursts);

   //////////////////////////////
   // read address
   //////////////////////////////

   // load page start, then step one burst after each rlast
   always_ff @(posedge sysclk_i)
   begin
      if (read_cmd_i && rd_state == ddr_page_pkg::rd_idle)
         araddr_o <= start_addr;
      else if (last_beat && !final_burst)
         araddr_o <= araddr_o + burst_ofs;
   end

   //////////////////////////////
   // read fsm
   //////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         rd_state    <= ddr_page_pkg::rd_idle;
         arvalid_o   <= 1'b0;
         burst_cnt   <= '0;
         n_bursts    <= '0;
         read_done_o <= 1'b0;
      end
      else
      begin
         case (rd_state)
            ddr_page_pkg::rd_idle:
            begin
               burst_cnt <= '0;
               if (read_cmd_i)
               begin
                  n_bursts  <= read_bursts_i;
                  arvalid_o <= 1'b1;
                  rd_state  <= ddr_page_pkg::rd_addr;
               end
            end
            ddr_page_pkg::rd_addr:
            begin
               if (arready_i)
               begin
                  arvalid_o <= 1'b0;
                  rd_state  <= ddr_page_pkg::rd_data;
               end
            end
            // next address waits for rlast of the current burst
            ddr_page_pkg::rd_data:
            begin
               if (last_beat)
               begin
                  burst_cnt <= burst_cnt + 1'b1;
                  if (final_burst)
                  begin
                     read_done_o <= 1'b1;
                     rd_state    <= ddr_page_pkg::rd_done;
                  end
                  else
                  begin
                     arvalid_o <= 1'b1;
                     rd_state  <= ddr_page_pkg::rd_addr;
                  end
               end
            end
            // done pulse lasts this one cycle
            ddr_page_pkg::rd_done:
            begin
               read_done_o <= 1'b0;
               rd_state    <= ddr_page_pkg::rd_idle;
            end
            default:
               rd_state <= ddr_page_pkg::rd_idle;
         endcase
      end
   end

   //////////////////////////////
   // destination fifo port
   //////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
         memfifo_we_o <= 1'b0;
      else
         memfifo_we_o <= r_hs;
   end

   // word follows the write enable by the same one cycle
   always_ff @(posedge sysclk_i)
   begin
      if (r_hs)
         memfifo_data_o <= rdata_i;
   end

endmodule

/* ddr_page_buffer.sv */
`timescale 1ns/100ps

module ddr_page_buffer
#(
   parameter ddr_axi_pkg::axi_len_t  burst_len  = 8'd255,
   parameter ddr_axi_pkg::axi_size_t burst_size = 2'd3
)
(
   input  logic                     sysclk_i,
   input  logic                     reset,
   // commands and configuration
   input  logic                     write_cmd_i,
   input  logic                     read_cmd_i,
   input  ddr_page_pkg::page_cnt_t  write_pages_i,
   input  ddr_page_pkg::page_ofs_t  mem_ofs_i,
   input  ddr_page_pkg::burst_cnt_t read_bursts_i,
   output logic                     write_done_o,
   output logic                     read_done_o,
   output logic                     last_write_o,
   output logic                     mem_full_o,
   output ddr_page_pkg::page_cnt_t  wr_page_o,
   output ddr_page_pkg::page_cnt_t  rd_page_o,
   // source and destination fifo
   input  logic                     fifo_empty_i,
   input  ddr_axi_pkg::axi_data_t   fifo_data_i,
   output logic                     fifo_re_o,
   output ddr_axi_pkg::axi_data_t   memfifo_data_o,
   output logic                     memfifo_we_o,
   // axi write channels
   output ddr_axi_pkg::axi_addr_t   awaddr_o,
   output ddr_axi_pkg::axi_len_t    awlen_o,
   output ddr_axi_pkg::axi_size_t   awsize_o,
   output logic [1:0]               awburst_o,
   output logic                     awvalid_o,
   input  logic                     awready_i,
   output ddr_axi_pkg::axi_data_t   wdata_o,
   output logic [7:0]               wstrb_o,
   output logic                     wvalid_o,
   output logic                     wlast_o,
   input  logic                     wready_i,
   input  logic                     bvalid_i,
   output logic                     bready_o,
   // axi read channels
   output ddr_axi_pkg::axi_addr_t   araddr_o,
   output ddr_axi_pkg::axi_len_t    arlen_o,
   output ddr_axi_pkg::axi_size_t   arsize_o,
   output logic [1:0]               arburst_o,
   output logic                     arvalid_o,
   input  logic                     arready_i,
   input  ddr_axi_pkg::axi_data_t   rdata_i,
   input  logic                     rvalid_i,
   input  logic                     rlast_i,
   output logic                     rready_o
);

   // accepted write command, tracker to write engine
   logic write_go;

   //////////////////////////////
   // burst attributes
   //////////////////////////////

   // same burst shape on both directions
   assign awlen_o   = burst_len;
   assign awsize_o  = burst_size;
   assign awburst_o = ddr_axi_pkg::axi_burst_incr;
   assign wstrb_o   = ddr_axi_pkg::axi_strb_all;
   assign arlen_o   = burst_len;
   assign arsize_o  = burst_size;
   assign arburst_o = ddr_axi_pkg::axi_burst_incr;

   ddr_page_tracker tracker_i (
      .sysclk_i      (sysclk_i),
      .reset         (reset),
      .write_cmd_i   (write_cmd_i),
      .read_cmd_i    (read_cmd_i),
      .write_done_i  (write_done_o),
      .read_done_i   (read_done_o),
      .write_pages_i (write_pages_i),
      .write_go_o    (write_go),
      .wr_page_o     (wr_page_o),
      .rd_page_o     (rd_page_o),
      .last_write_o  (last_write_o),
      .mem_full_o    (mem_full_o)
   );

   ddr_write_engine #(
      .burst_len  (burst_len),
      .burst_size (burst_size)
   ) write_i (
      .sysclk_i     (sysclk_i),
      .reset        (reset),
      .write_go_i   (write_go),
      .wr_page_i    (wr_page_o),
      .mem_ofs_i    (mem_ofs_i),
      .fifo_empty_i (fifo_empty_i),
      .fifo_data_i  (fifo_data_i),
      .awready_i    (awready_i),
      .wready_i     (wready_i),
      .bvalid_i     (bvalid_i),
      .fifo_re_o    (fifo_re_o),
      .awaddr_o     (awaddr_o),
      .awvalid_o    (awvalid_o),
      .wdata_o      (wdata_o),
      .wvalid_o     (wvalid_o),
      .wlast_o      (wlast_o),
      .bready_o     (bready_o),
      .write_done_o (write_done_o)
   );

   ddr_read_engine #(
      .burst_len  (burst_len),
      .burst_size (burst_size)
   ) read_i (
      .sysclk_i       (sysclk_i),
      .reset          (reset),
      .read_cmd_i     (read_cmd_i),
      .rd_page_i      (rd_page_o),
      .mem_ofs_i      (mem_ofs_i),
      .read_bursts_i  (read_bursts_i),
      .arready_i      (arready_i),
      .rdata_i        (rdata_i),
      .rvalid_i       (rvalid_i),
      .rlast_i        (rlast_i),
      .araddr_o       (araddr_o),
      .arvalid_o      (arvalid_o),
      .rready_o       (rready_o),
      .memfifo_data_o (memfifo_data_o),
      .memfifo_we_o   (memfifo_we_o),
      .read_done_o    (read_done_o)
   );

endmodule

/* tb_axi_slave_mem.sv */
`timescale 1ns/100ps

module tb_axi_slave_mem
#(
   parameter int beats = 8
)
(
   input  logic        sysclk_i,
   input  logic        reset,
   input  logic [31:0] awaddr_i,
   input  logic        awvalid_i,
   output logic        awready_o,
   input  logic [63:0] wdata_i,
   input  logic        wvalid_i,
   input  logic        wlast_i,
   output logic        wready_o,
   output logic        bvalid_o,
   input  logic        bready_i,
   input  logic [31:0] araddr_i,
   input  logic        arvalid_i,
   output logic        arready_o,
   output logic [63:0] rdata_o,
   output logic        rvalid_o,
   output logic        rlast_o,
   input  logic        rready_i
);

   // sparse ddr image keyed by byte address
   logic [63:0] mem [logic [31:0]];
   // one random ready draw per channel
   logic        aw_rdy_q;
   logic        w_rdy_q;
   logic        ar_rdy_q;
   // one burst in flight per direction
   logic        wr_busy;
   logic        rd_busy;
   logic [31:0] w_addr;
   logic [31:0] r_addr;
   int          w_beat;
   int          r_beat;

   // unwritten locations read back as a pattern of their own address
   function automatic logic [63:0] read_word(input logic [31:0] addr);
      if (mem.exists(addr))
         return mem[addr];
      return {~addr, addr};
   endfunction

   assign awready_o = aw_rdy_q & ~wr_busy;
   assign wready_o  = w_rdy_q & wr_busy & ~bvalid_o;
   assign arready_o = ar_rdy_q & ~rd_busy;

   //////////////////////////////
   // write side
   //////////////////////////////

   always @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         aw_rdy_q <= 1'b0;
         w_rdy_q  <= 1'b0;
         ar_rdy_q <= 1'b0;
         wr_busy  <= 1'b0;
         w_addr   <= '0;
         w_beat   <= 0;
         bvalid_o <= 1'b0;
      end
      else
      begin
         // about one stall in three on every ready
         aw_rdy_q <= ($urandom % 3) != 0;
         w_rdy_q  <= ($urandom % 3) != 0;
         ar_rdy_q <= ($urandom % 3) != 0;
         if (awvalid_i && awready_o)
         begin
            wr_busy <= 1'b1;
            w_addr  <= awaddr_i;
            w_beat  <= 0;
         end
         // incr burst of 8 bytes per beat
         if (wvalid_i && wready_o)
         begin
            mem[w_addr + 32'(w_beat * 8)] = wdata_i;
            w_beat <= w_beat + 1;
            if (wlast_i)
               bvalid_o <= 1'b1;
         end
         if (bvalid_o && bready_i)
         begin
            bvalid_o <= 1'b0;
            wr_busy  <= 1'b0;
         end
      end
   end

   //////////////////////////////
   // read side
   //////////////////////////////

   always @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         rd_busy  <= 1'b0;
         r_addr   <= '0;
         r_beat   <= 0;
         rvalid_o <= 1'b0;
         rlast_o  <= 1'b0;
         rdata_o  <= '0;
      end
      else
      begin
         if (arvalid_i && arready_o)
         begin
            rd_busy <= 1'b1;
            r_addr  <= araddr_i;
            r_beat  <= 0;
         end
         // a taken beat is followed by a gap of at least one cycle
         if (rvalid_o && rready_i)
         begin
            rvalid_o <= 1'b0;
            rlast_o  <= 1'b0;
            r_beat   <= r_beat + 1;
            if (rlast_o)
               rd_busy <= 1'b0;
         end
         else if (rd_busy && !rvalid_o && ($urandom % 3) != 0)
         begin
            rvalid_o <= 1'b1;
            rdata_o  <= read_word(r_addr + 32'(r_beat * 8));
            rlast_o  <= (r_beat == beats - 1);
         end
      end
   end

endmodule

/* tb_ddr_page_buffer.sv */
`timescale 1ns/100ps

module tb_ddr_page_buffer;

   localparam int beats       = 8;
   localparam int burst_bytes = 64;
   localparam int page_ofs    = 5;
   localparam int n_pages     = 4;
   // 8 pages of 8 beats with random stalls fit well inside this
   localparam int max_cycles  = 20000;

   logic                     sysclk;
   logic                     reset;
   logic                     write_cmd;
   logic                     read_cmd;
   ddr_page_pkg::page_cnt_t  write_pages;
   ddr_page_pkg::page_ofs_t  mem_ofs;
   ddr_page_pkg::burst_cnt_t read_bursts;
   logic                     write_done;
   logic                     read_done;
   logic                     last_write;
   logic                     mem_full;
   ddr_page_pkg::page_cnt_t  wr_page;
   ddr_page_pkg::page_cnt_t  rd_page;
   logic                     fifo_empty;
   ddr_axi_pkg::axi_data_t   fifo_data;
   logic                     fifo_re;
   ddr_axi_pkg::axi_data_t   memfifo_data;
   logic                     memfifo_we;
   ddr_axi_pkg::axi_addr_t   awaddr;
   ddr_axi_pkg::axi_len_t    awlen;
   ddr_axi_pkg::axi_size_t   awsize;
   logic [1:0]               awburst;
   logic                     awvalid;
   logic                     awready;
   ddr_axi_pkg::axi_data_t   wdata;
   logic [7:0]               wstrb;
   logic                     wvalid;
   logic                     wlast;
   logic                     wready;
   logic                     bvalid;
   logic                     bready;
   ddr_axi_pkg::axi_addr_t   araddr;
   ddr_axi_pkg::axi_len_t    arlen;
   ddr_axi_pkg::axi_size_t   arsize;
   logic [1:0]               arburst;
   logic                     arvalid;
   logic                     arready;
   ddr_axi_pkg::axi_data_t   rdata;
   logic                     rvalid;
   logic                     rlast;
   logic                     rready;

   // source fifo contents and words seen on the destination port
   ddr_axi_pkg::axi_data_t   src_q[$];
   ddr_axi_pkg::axi_data_t   rd_q[$];
   // expected words of each page
   ddr_axi_pkg::axi_data_t   model_page [0:n_pages-1][0:beats-1];
   int                       errors;
   int                       tests_run;
   int                       tests_failed;
   int                       cycle_cnt;

   ddr_page_buffer #(
      .burst_len  (8'd7),
      .burst_size (2'd3)
   ) dut_i (
      .sysclk_i (sysclk), .reset (reset),
      .write_cmd_i (write_cmd), .read_cmd_i (read_cmd),
      .write_pages_i (write_pages), .mem_ofs_i (mem_ofs), .read_bursts_i (read_bursts),
      .write_done_o (write_done), .read_done_o (read_done),
      .last_write_o (last_write), .mem_full_o (mem_full),
      .wr_page_o (wr_page), .rd_page_o (rd_page),
      .fifo_empty_i (fifo_empty), .fifo_data_i (fifo_data), .fifo_re_o (fifo_re),
      .memfifo_data_o (memfifo_data), .memfifo_we_o (memfifo_we),
      .awaddr_o (awaddr), .awlen_o (awlen), .awsize_o (awsize), .awburst_o (awburst),
      .awvalid_o (awvalid), .awready_i (awready),
      .wdata_o (wdata), .wstrb_o (wstrb), .wvalid_o (wvalid), .wlast_o (wlast),
      .wready_i (wready), .bvalid_i (bvalid), .bready_o (bready),
      .araddr_o (araddr), .arlen_o (arlen), .arsize_o (arsize), .arburst_o (arburst),
      .arvalid_o (arvalid), .arready_i (arready),
      .rdata_i (rdata), .rvalid_i (rvalid), .rlast_i (rlast), .rready_o (rready)
   );

   tb_axi_slave_mem #(.beats (beats)) slave_i (
      .sysclk_i (sysclk), .reset (reset),
      .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
      .wdata_i (wdata), .wvalid_i (wvalid), .wlast_i (wlast), .wready_o (wready),
      .bvalid_o (bvalid), .bready_i (bready),
      .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
      .rdata_o (rdata), .rvalid_o (rvalid), .rlast_o (rlast), .rready_i (rready)
   );

   initial
      sysclk = 1'b0;
   always #5 sysclk = ~sysclk;

   //////////////////////////////
   // fifo models and watchdog
   //////////////////////////////

   // show-ahead source that pops on read enable and goes empty one cycle in four at random
   always @(posedge sysclk)
   begin
      if (fifo_re)
         void'(src_q.pop_front());
      fifo_empty <= (src_q.size() == 0) || (($urandom % 4) == 0);
      fifo_data  <= (src_q.size() == 0) ? '0 : src_q[0];
   end

   always @(posedge sysclk)
   begin
      if (memfifo_we)
         rd_q.push_back(memfifo_data);
   end

   always @(posedge sysclk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles)
      begin
         $display("timeout: no progress after %0d cycles, run stopped", cycle_cnt);
         $display("Simulation failed");
         $finish;
      end
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   task automatic check_val(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
      if (expected !== actual)
      begin
         errors++;
         $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before)
         $display("test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %s: FAIL, %0d errors", name, errors - errs_before);
      end
   endtask

   // fill the source fifo with one page of random words and write it
   task automatic write_page(input int page);
      ddr_axi_pkg::axi_data_t word;
      for (int b = 0; b < beats; b++)
      begin
         word = {$urandom, $urandom};
         model_page[page][b] = word;
         src_q.push_back(word);
      end
      @(posedge sysclk);
      write_cmd <= 1'b1;
      @(posedge sysclk);
      write_cmd <= 1'b0;
      do
         @(posedge sysclk);
      while (write_done !== 1'b1);
   endtask

   // memory image against the address rule
   task automatic check_page_mem(input int page);
      logic [31:0] addr;
      for (int b = 0; b < beats; b++)
      begin
         addr = 32'(burst_bytes * (page + page_ofs) + 8 * b);
         check_val($sformatf("mem[%h]", addr), model_page[page][b], slave_i.read_word(addr));
      end
   endtask

   // one read command and a compare of everything that came out
   task automatic read_pages(input int first_page, input int n_bursts);
      rd_q.delete();
      read_bursts <= 8'(n_bursts);
      @(posedge sysclk);
      read_cmd <= 1'b1;
      @(posedge sysclk);
      read_cmd <= 1'b0;
      do
         @(posedge sysclk);
      while (read_done !== 1'b1);
      // let the last registered beat reach the queue
      repeat (3) @(posedge sysclk);
      check_val("memfifo_we_o beat count", 64'(n_bursts * beats), 64'(rd_q.size()));
      for (int i = 0; i < n_bursts * beats && i < rd_q.size(); i++)
         check_val("memfifo_data_o", model_page[first_page + i / beats][i % beats], rd_q[i]);
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial
   begin
      int errs0;
      logic aw_seen;
      void'($urandom(32'hcc70b34d));
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      cycle_cnt    = 0;
      reset        = 1'b1;
      write_cmd    = 1'b0;
      read_cmd     = 1'b0;
      write_pages  = 32'(n_pages);
      mem_ofs      = 20'(page_ofs);
      read_bursts  = 8'd1;
      fifo_empty   = 1'b1;
      fifo_data    = '0;
      repeat (3) @(posedge sysclk);
      reset <= 1'b0;
      repeat (2) @(posedge sysclk);

      errs0 = errors;
      check_val("awvalid_o", 64'(0), 64'(awvalid));
      check_val("wvalid_o", 64'(0), 64'(wvalid));
      check_val("arvalid_o", 64'(0), 64'(arvalid));
      check_val("fifo_re_o", 64'(0), 64'(fifo_re));
      check_val("memfifo_we_o", 64'(0), 64'(memfifo_we));
      check_val("mem_full_o", 64'(0), 64'(mem_full));
      check_val("write_done_o", 64'(0), 64'(write_done));
      check_val("read_done_o", 64'(0), 64'(read_done));
      check_val("wr_page_o", 64'(0), 64'(wr_page));
      check_val("rd_page_o", 64'(0), 64'(rd_page));
      report_test("reset", errs0);

      // 8 beats of 8 bytes, incr bursts, all lanes and the response always taken
      errs0 = errors;
      check_val("awlen_o", 64'(beats - 1), 64'(awlen));
      check_val("awsize_o", 64'(3), 64'(awsize));
      check_val("awburst_o", 64'(2'b01), 64'(awburst));
      check_val("wstrb_o", 64'(8'hff), 64'(wstrb));
      check_val("bready_o", 64'(1), 64'(bready));
      check_val("arlen_o", 64'(beats - 1), 64'(arlen));
      check_val("arsize_o", 64'(3), 64'(arsize));
      check_val("arburst_o", 64'(2'b01), 64'(arburst));
      report_test("burst attributes", errs0);

      errs0 = errors;
      for (int p = 0; p < n_pages; p++)
      begin
         write_page(p);
         check_page_mem(p);
      end
      report_test("page write", errs0);

      // full flag and a write that must be dropped
      errs0 = errors;
      repeat (2) @(posedge sysclk);
      check_val("mem_full_o", 64'(1), 64'(mem_full));
      check_val("last_write_o", 64'(1), 64'(last_write));
      write_cmd <= 1'b1;
      @(posedge sysclk);
      write_cmd <= 1'b0;
      aw_seen = 1'b0;
      repeat (40)
      begin
         @(posedge sysclk);
         aw_seen = aw_seen | awvalid;
      end
      check_val("awvalid_o while full", 64'(0), 64'(aw_seen));
      check_val("wr_page_o while full", 64'(n_pages), 64'(wr_page));
      report_test("memory full", errs0);

      errs0 = errors;
      for (int p = 0; p < n_pages; p++)
         read_pages(p, 1);
      report_test("page read", errs0);

      // last read brought the counters back to zero
      errs0 = errors;
      check_val("wr_page_o", 64'(0), 64'(wr_page));
      check_val("rd_page_o", 64'(0), 64'(rd_page));
      check_val("mem_full_o", 64'(0), 64'(mem_full));
      report_test("restart", errs0);

      errs0 = errors;
      read_pages(0, 2);
      report_test("two burst read", errs0);

      // second round lands at the same page offset
      errs0 = errors;
      for (int p = 0; p < n_pages; p++)
      begin
         write_page(p);
         check_page_mem(p);
      end
      report_test("rewrite after restart", errs0);

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* build.f */
ddr_axi_pkg.sv
ddr_page_pkg.sv
ddr_page_tracker.sv
ddr_write_engine.sv
ddr_read_engine.sv
ddr_page_buffer.sv
tb_axi_slave_mem.sv
tb_ddr_page_buffer.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and judge the log
verilator --binary -f build.f --top-module tb_ddr_page_buffer -o tb_sim > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
